// File: project.f
src/cast_pkg.sv
src/cast_unpack.sv
src/cast_normalize.sv
src/cast_round_pack.sv
src/cast_top.sv
dv/cast_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cast testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cast_tb -f project.f -o cast_sim

./obj_dir/cast_sim | tee sim.log

# Pass only if the testbench reported it
grep -q "TESTBENCH PASSED" sim.log
echo "Simulation passed"

// File: dv/cast_tb.sv
`default_nettype none

module cast_tb;

  localparam int TAG_W      = 4;
  localparam int N_DIRECTED = 29;
  localparam int N_RAND     = 300;
  localparam int N_TESTS    = N_DIRECTED + N_RAND;  // Slots including idle ones

  logic                clk_i;
  logic                arst_n_i;
  logic                in_valid_i;
  logic [31:0]         operand_i;
  cast_pkg::op_e       op_i;
  logic                is_unsigned_i;
  cast_pkg::rnd_mode_e rnd_mode_i;
  logic [TAG_W-1:0]    tag_i;
  logic                out_valid_o;
  logic [31:0]         result_o;
  cast_pkg::status_t   status_o;
  logic [TAG_W-1:0]    tag_o;

  // Expected results in issue order
  logic [31:0]       exp_res [N_TESTS];
  cast_pkg::status_t exp_st  [N_TESTS];
  logic [TAG_W-1:0]  exp_tag [N_TESTS];
  int                exp_cyc [N_TESTS];  // Cycle the pulse is due
  int                wr_idx  = 0;
  int                rd_idx  = 0;
  int                cyc     = 0;
  int                err_cnt = 0;
  integer            seed    = 6;

  cast_top #(
    .TagWidth ( TAG_W )
  ) dut (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .in_valid_i    ( in_valid_i    ),
    .operand_i     ( operand_i     ),
    .op_i          ( op_i          ),
    .is_unsigned_i ( is_unsigned_i ),
    .rnd_mode_i    ( rnd_mode_i    ),
    .tag_i         ( tag_i         ),
    .out_valid_o   ( out_valid_o   ),
    .result_o      ( result_o      ),
    .status_o      ( status_o      ),
    .tag_o         ( tag_o         )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (arst_n_i && out_valid_o) begin
      rd_idx <= rd_idx + 1;  // Head consumed after the negedge checks
    end
  end

  // --------------------
  // Reference models
  // --------------------
  // Returns {nv, nx, result}
  function automatic logic [33:0] i2f_model(input logic [31:0] a, input logic uns,
                                            input logic rtz);
    logic        s;
    logic [31:0] mag;
    logic [32:0] kept;  // 1.fraction with carry room in bit 24
    logic [31:0] rem;
    logic [31:0] half;
    int          p;
    int          e;
    int          sh;
    s   = a[31] & ~uns;
    mag = s ? -a : a;
    if (mag == 32'd0) begin
      return 34'd0;  // Always +0
    end
    p = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) begin
        p = i;  // Leading one
      end
    end
    e    = p + 127;
    sh   = (p > 23) ? p - 23 : 0;
    kept = (p > 23) ? {1'b0, mag >> sh} : {1'b0, mag << (23 - p)};
    rem  = mag & ((32'd1 << sh) - 32'd1);  // Dropped bits
    half = (sh > 0) ? (32'd1 << (sh - 1)) : 32'd0;
    if (!rtz && sh > 0 && (rem > half || (rem == half && kept[0]))) begin
      kept = kept + 33'd1;
    end
    if (kept[24]) begin
      kept = kept >> 1;  // Carry into exponent
      e    = e + 1;
    end
    return {1'b0, rem != 32'd0, s, e[7:0], kept[22:0]};
  endfunction

  function automatic logic [33:0] f2i_model(input logic [31:0] a, input logic uns,
                                            input logic rtz);
    logic        s;
    logic [63:0] m;
    logic [63:0] ip;  // Integer part
    logic [63:0] rem;
    logic [63:0] half;
    logic [31:0] sat;
    int          e;
    int          sh;
    s   = a[31];
    e   = int'(a[30:23]) - 127;
    m   = {40'd0, 1'b1, a[22:0]};
    sat = s ? (uns ? 32'd0 : 32'h8000_0000) : (uns ? 32'hFFFF_FFFF : 32'h7FFF_FFFF);
    if (a[30:23] == 8'hFF && a[22:0] != 23'd0) begin
      return {2'b10, uns ? 32'hFFFF_FFFF : 32'h7FFF_FFFF};  // NaN ignores sign
    end
    if (a[30:23] == 8'hFF || e >= 31 + int'(uns)) begin
      return {2'b10, sat};
    end
    if (a[30:23] == 8'd0) begin
      return {1'b0, a[22:0] != 23'd0, 32'd0};  // Below one half
    end
    sh   = (23 - e > 40) ? 40 : 23 - e;
    rem  = 64'd0;
    half = 64'd0;
    if (sh <= 0) begin
      ip = m << -sh;
    end else begin
      ip   = m >> sh;
      rem  = m & ((64'd1 << sh) - 64'd1);
      half = 64'd1 << (sh - 1);
    end
    if (!rtz && sh > 0 && (rem > half || (rem == half && ip[0]))) begin
      ip = ip + 64'd1;
    end
    if (s && uns && ip != 64'd0) begin
      return {2'b10, 32'd0};
    end
    return {1'b0, rem != 64'd0, s ? -ip[31:0] : ip[31:0]};
  endfunction

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic issue_op(input logic [31:0] a, input cast_pkg::op_e op, input logic uns,
                          input cast_pkg::rnd_mode_e rnd);
    logic [33:0] r;
    @(posedge clk_i);
    if (op == cast_pkg::I2F) begin
      r = i2f_model(a, uns, rnd == cast_pkg::RTZ);
    end else begin
      r = f2i_model(a, uns, rnd == cast_pkg::RTZ);
    end
    in_valid_i    <= 1'b1;
    operand_i     <= a;
    op_i          <= op;
    is_unsigned_i <= uns;
    rnd_mode_i    <= rnd;
    tag_i         <= wr_idx[TAG_W-1:0];
    exp_res[wr_idx] = r[31:0];
    exp_st[wr_idx]  = r[33:32];
    exp_tag[wr_idx] = wr_idx[TAG_W-1:0];
    exp_cyc[wr_idx] = cyc + 4;  // Next edge plus three stages
    wr_idx = wr_idx + 1;
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  // --------------------
  // Output checks
  // --------------------
  // Checked on the falling edge
  a_reset_quiet: assert property (@(negedge clk_i) !arst_n_i |-> !out_valid_o)
    else begin
      err_cnt++;
      $display("[ERROR] %0t out_valid_o during reset: expected 0, got %b", $time, out_valid_o);
    end

  a_pending: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    out_valid_o |-> rd_idx < wr_idx)
    else begin
      err_cnt++;
      $display("out_valid_o pulsed at %0t with no operation in flight", $time);
    end

  a_latency: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    out_valid_o |-> cyc == exp_cyc[rd_idx])
    else begin
      err_cnt++;
      $display("[ERROR] %0t out_valid_o cycle: expected %0d, got %0d",
               $time, exp_cyc[rd_idx], cyc);
    end

  a_result: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    out_valid_o |-> result_o == exp_res[rd_idx])
    else begin
      err_cnt++;
      $display("[ERROR] %0t result_o: expected %h, got %h", $time, exp_res[rd_idx], result_o);
    end

  a_status: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    out_valid_o |-> status_o == exp_st[rd_idx])
    else begin
      err_cnt++;
      $display("[ERROR] %0t status_o: expected %b, got %b", $time, exp_st[rd_idx], status_o);
    end

  a_tag: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    out_valid_o |-> tag_o == exp_tag[rd_idx])
    else begin
      err_cnt++;
      $display("[ERROR] %0t tag_o: expected %h, got %h", $time, exp_tag[rd_idx], tag_o);
    end

  initial begin
    #((N_TESTS + 20) * 10);
    $display("Timeout at %0t, %0d of %0d results seen", $time, rd_idx, wr_idx);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    logic [31:0] ctl;
    logic [31:0] rnd_a;
    arst_n_i      = 1'b0;
    in_valid_i    = 1'b0;
    operand_i     = '0;
    op_i          = cast_pkg::F2I;
    is_unsigned_i = 1'b0;
    rnd_mode_i    = cast_pkg::RNE;
    tag_i         = '0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    idle_cycle();
    // I2F exact then rounded
    issue_op(32'h0000_0000, cast_pkg::I2F, 1'b0, cast_pkg::RNE);
    issue_op(32'h0000_0001, cast_pkg::I2F, 1'b0, cast_pkg::RNE);
    issue_op(32'hFFFF_FFFF, cast_pkg::I2F, 1'b0, cast_pkg::RNE);  // -1
    issue_op(32'h00FF_FFFF, cast_pkg::I2F, 1'b1, cast_pkg::RNE);
    issue_op(32'h8000_0000, cast_pkg::I2F, 1'b0, cast_pkg::RTZ);  // -2^31
    issue_op(32'hFFFF_FFFF, cast_pkg::I2F, 1'b1, cast_pkg::RNE);  // Carry to 2^32
    issue_op(32'hFFFF_FFFF, cast_pkg::I2F, 1'b1, cast_pkg::RTZ);
    issue_op(32'h0100_0001, cast_pkg::I2F, 1'b1, cast_pkg::RNE);  // Tie stays even
    issue_op(32'h0100_0003, cast_pkg::I2F, 1'b1, cast_pkg::RNE);  // Tie rounds up
    issue_op(32'h7FFF_FFFF, cast_pkg::I2F, 1'b0, cast_pkg::RTZ);
    // F2I in range
    issue_op(32'h4020_0000, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // 2.5
    issue_op(32'h4060_0000, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // 3.5
    issue_op(32'hC020_0000, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // -2.5
    issue_op(32'h4020_0000, cast_pkg::F2I, 1'b0, cast_pkg::RTZ);
    issue_op(32'h3F00_0000, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // 0.5
    issue_op(32'h3F40_0000, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // 0.75
    issue_op(32'h0000_0001, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // Smallest subnormal
    issue_op(32'h0000_0000, cast_pkg::F2I, 1'b1, cast_pkg::RNE);
    issue_op(32'h8000_0000, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // -0
    // F2I special cases
    issue_op(32'h7FC0_0000, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // qNaN
    issue_op(32'h7F80_0001, cast_pkg::F2I, 1'b1, cast_pkg::RNE);  // sNaN
    issue_op(32'h7F80_0000, cast_pkg::F2I, 1'b0, cast_pkg::RTZ);  // +Inf
    issue_op(32'hFF80_0000, cast_pkg::F2I, 1'b1, cast_pkg::RNE);  // -Inf
    issue_op(32'h4F00_0000, cast_pkg::F2I, 1'b0, cast_pkg::RNE);  // 2^31
    issue_op(32'h4F00_0000, cast_pkg::F2I, 1'b1, cast_pkg::RNE);
    issue_op(32'h4F80_0000, cast_pkg::F2I, 1'b1, cast_pkg::RTZ);  // 2^32
    issue_op(32'hC000_0000, cast_pkg::F2I, 1'b1, cast_pkg::RNE);  // -2 to unsigned
    issue_op(32'hBE99_999A, cast_pkg::F2I, 1'b1, cast_pkg::RTZ);  // -0.3 truncates to 0
    issue_op(32'h4B7F_FFFF, cast_pkg::F2I, 1'b0, cast_pkg::RNE);
    // Random mix with idle gaps
    for (int i = 0; i < N_RAND; i++) begin
      ctl   = $random(seed);
      rnd_a = $random(seed);
      if (ctl[5] && !ctl[0]) begin
        rnd_a[30:23] = 8'd123 + {2'b00, ctl[13:8] % 6'd40};  // Around integer range
      end else if (ctl[5]) begin
        rnd_a = rnd_a >> ctl[20:16];  // Small magnitudes
      end
      if (ctl[4:3] == 2'b00) begin
        idle_cycle();
      end else begin
        issue_op(rnd_a, ctl[0] ? cast_pkg::I2F : cast_pkg::F2I, ctl[1],
                 ctl[2] ? cast_pkg::RTZ : cast_pkg::RNE);
      end
    end
    idle_cycle();
    while (rd_idx != wr_idx) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    $display("Issued %0d, checked %0d, errors %0d", wr_idx, rd_idx, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/cast_top.sv
`default_nettype none

module cast_top #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  input  logic [31:0]           operand_i,
  input  cast_pkg::op_e         op_i,
  input  logic                  is_unsigned_i,
  input  cast_pkg::rnd_mode_e   rnd_mode_i,
  input  logic [TagWidth-1:0]   tag_i,
  output logic                  out_valid_o,
  output logic [31:0]           result_o,
  output cast_pkg::status_t     status_o,
  output logic [TagWidth-1:0]   tag_o
);

  // --------------------
  // Stage links
  // --------------------
  logic                u_valid;
  cast_pkg::unpacked_t u_data;
  logic [TagWidth-1:0] u_tag;

  logic                a_valid;
  cast_pkg::aligned_t  a_data;
  logic [TagWidth-1:0] a_tag;

  // Stage 1, classify and take magnitude
  cast_unpack #(
    .TagWidth ( TagWidth )
  ) u_unpack (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .in_valid_i    ( in_valid_i    ),
    .operand_i     ( operand_i     ),
    .op_i          ( op_i          ),
    .is_unsigned_i ( is_unsigned_i ),
    .rnd_mode_i    ( rnd_mode_i    ),
    .tag_i         ( tag_i         ),
    .valid_o       ( u_valid       ),
    .data_o        ( u_data        ),
    .tag_o         ( u_tag         )
  );

  // Stage 2, normalize and align
  cast_normalize #(
    .TagWidth ( TagWidth )
  ) u_normalize (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .valid_i  ( u_valid  ),
    .data_i   ( u_data   ),
    .tag_i    ( u_tag    ),
    .valid_o  ( a_valid  ),
    .data_o   ( a_data   ),
    .tag_o    ( a_tag    )
  );

  // Stage 3, round and pack
  cast_round_pack #(
    .TagWidth ( TagWidth )
  ) u_round_pack (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .valid_i  ( a_valid     ),
    .data_i   ( a_data      ),
    .tag_i    ( a_tag       ),
    .valid_o  ( out_valid_o ),
    .result_o ( result_o    ),
    .status_o ( status_o    ),
    .tag_o    ( tag_o       )
  );

endmodule

`default_nettype wire

// File: src/cast_round_pack.sv
`default_nettype none

module cast_round_pack #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  cast_pkg::aligned_t    data_i,
  input  logic [TagWidth-1:0]   tag_i,
  output logic                  valid_o,
  output logic [31:0]           result_o,
  output cast_pkg::status_t     status_o,
  output logic [TagWidth-1:0]   tag_o
);

  // --------------------
  // Rounding
  // --------------------
  logic                           round_up;
  logic                           inexact;
  logic [cast_pkg::INT_WIDTH-1:0] rounded;  // Magnitude after rounding
  logic [cast_pkg::INT_WIDTH-1:0] int_res;  // Signed integer result

  // RNE on the magnitude and RTZ never adds
  assign round_up = (data_i.rnd_mode == cast_pkg::RNE) & data_i.round_bit &
                    (data_i.sticky_bit | data_i.pre_round[0]);
  assign inexact  = data_i.round_bit | data_i.sticky_bit;

  // Fraction carry runs into the exponent for I2F
  assign rounded = data_i.pre_round + {{(cast_pkg::INT_WIDTH-1){1'b0}}, round_up};
  assign int_res = data_i.sign ? -rounded : rounded;

  // --------------------
  // F2I special cases
  // --------------------
  logic                           f2i_special;
  logic [cast_pkg::INT_WIDTH-1:0] special_res;

  assign f2i_special = data_i.fclass.is_nan | data_i.fclass.is_inf | data_i.of_before_round |
                       (data_i.sign & data_i.is_unsigned & (rounded != '0));

  always_comb begin
    special_res = {data_i.is_unsigned, {(cast_pkg::INT_WIDTH-1){1'b1}}};  // Max positive
    if (data_i.sign && !data_i.fclass.is_nan) begin
      special_res = ~special_res;  // Signed min or zero
    end
  end

  // --------------------
  // Result select
  // --------------------
  logic [31:0]       result_d;
  cast_pkg::status_t status_d;

  always_comb begin
    if (data_i.op == cast_pkg::F2I) begin
      if (f2i_special) begin
        result_d = special_res;
        status_d = '{nv: 1'b1, nx: 1'b0};
      end else begin
        result_d = int_res;
        status_d = '{nv: 1'b0, nx: inexact};
      end
    end else begin
      if (data_i.mant_zero) begin
        result_d = '0;  // Integer zero is +0
        status_d = '0;
      end else begin
        result_d = {data_i.sign, rounded[cast_pkg::INT_WIDTH-2:0]};  // Exponent stays below Inf
        status_d = '{nv: 1'b0, nx: inexact};
      end
    end
  end

  // --------------------
  // Stage 3 register
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= result_d;
      status_o <= status_d;
      tag_o    <= tag_i;
    end
  end

  a_flags_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o |-> !(status_o.nv && status_o.nx));

endmodule

`default_nettype wire

// File: src/cast_normalize.sv
`default_nettype none

module cast_normalize #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  cast_pkg::unpacked_t   data_i,
  input  logic [TagWidth-1:0]   tag_i,
  output logic                  valid_o,
  output cast_pkg::aligned_t    data_o,
  output logic [TagWidth-1:0]   tag_o
);

  // --------------------
  // Leading zero count
  // --------------------
  cast_pkg::lzc_t  lz;
  cast_pkg::mant_t norm_mant;  // MSB set unless zero

  always_comb begin
    lz = cast_pkg::lzc_t'(cast_pkg::MANT_WIDTH);  // All zero
    // Highest set bit wins
    for (int i = 0; i < cast_pkg::MANT_WIDTH; i++) begin
      if (data_i.mant[i]) begin
        lz = cast_pkg::lzc_t'(cast_pkg::MANT_WIDTH - 1 - i);
      end
    end
  end

  assign norm_mant = data_i.mant << lz;

  // --------------------
  // Exponents
  // --------------------
  cast_pkg::exp_t fp_exp;     // Unbiased float exponent
  cast_pkg::exp_t int_exp;    // Weight of integer MSB
  cast_pkg::exp_t i2f_exp;    // Rebiased for float32
  cast_pkg::exp_t f2i_limit;  // First exponent that overflows
  cast_pkg::exp_t shamt;      // Right shift to integer position

  // Subnormals use exponent 1, LZC offset undone for the fraction width
  assign fp_exp = cast_pkg::exp_t'(data_i.exp_biased)
                + cast_pkg::exp_t'(data_i.fclass.is_subnormal)
                - cast_pkg::exp_t'(cast_pkg::FP_BIAS)
                - cast_pkg::exp_t'(lz)
                + cast_pkg::exp_t'(cast_pkg::MANT_WIDTH - 1 - cast_pkg::MAN_BITS);

  assign int_exp = cast_pkg::exp_t'(cast_pkg::MANT_WIDTH - 1) - cast_pkg::exp_t'(lz);
  assign i2f_exp = int_exp + cast_pkg::exp_t'(cast_pkg::FP_BIAS);

  // Unsigned range is one bit wider
  assign f2i_limit = cast_pkg::exp_t'(cast_pkg::INT_WIDTH - 1)
                   + cast_pkg::exp_t'(data_i.is_unsigned);

  assign shamt = cast_pkg::exp_t'(cast_pkg::INT_WIDTH - 1) - fp_exp;

  // --------------------
  // Alignment
  // --------------------
  logic [2*cast_pkg::MANT_WIDTH-1:0] shifted;  // Integer on top, fraction below
  cast_pkg::aligned_t                data_d;

  assign shifted = {norm_mant, {cast_pkg::MANT_WIDTH{1'b0}}} >> shamt;

  always_comb begin
    data_d.op              = data_i.op;
    data_d.rnd_mode        = data_i.rnd_mode;
    data_d.is_unsigned     = data_i.is_unsigned;
    data_d.sign            = data_i.sign;
    data_d.fclass          = data_i.fclass;
    data_d.mant_zero       = (data_i.mant == '0);
    data_d.of_before_round = 1'b0;
    if (data_i.op == cast_pkg::I2F) begin
      // Drop the leading one, keep 23 fraction bits
      data_d.pre_round  = {1'b0, i2f_exp[cast_pkg::EXP_BITS-1:0],
                           norm_mant[cast_pkg::MANT_WIDTH-2 -: cast_pkg::MAN_BITS]};
      data_d.round_bit  = norm_mant[cast_pkg::MANT_WIDTH-cast_pkg::MAN_BITS-2];
      data_d.sticky_bit = |norm_mant[cast_pkg::MANT_WIDTH-cast_pkg::MAN_BITS-3:0];
    end else if (fp_exp >= f2i_limit) begin
      data_d.pre_round       = norm_mant;  // Saturated later
      data_d.round_bit       = 1'b0;
      data_d.sticky_bit      = 1'b0;
      data_d.of_before_round = 1'b1;  // Also catches Inf and NaN
    end else if (fp_exp < cast_pkg::exp_t'(-1)) begin
      // Below one half, everything is sticky
      data_d.pre_round  = '0;
      data_d.round_bit  = 1'b0;
      data_d.sticky_bit = ~data_i.fclass.is_zero;
    end else begin
      data_d.pre_round  = shifted[2*cast_pkg::MANT_WIDTH-1 -: cast_pkg::INT_WIDTH];
      data_d.round_bit  = shifted[cast_pkg::MANT_WIDTH-1];
      data_d.sticky_bit = |shifted[cast_pkg::MANT_WIDTH-2:0];
    end
  end

  // --------------------
  // Stage 2 register
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_o <= data_d;
      tag_o  <= tag_i;
    end
  end

  // Integer sources always fit a float32
  a_no_i2f_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && (data_o.op == cast_pkg::I2F) |-> !data_o.of_before_round);

endmodule

`default_nettype wire

// File: src/cast_unpack.sv
`default_nettype none

module cast_unpack #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  input  logic [31:0]           operand_i,
  input  cast_pkg::op_e         op_i,
  input  logic                  is_unsigned_i,
  input  cast_pkg::rnd_mode_e   rnd_mode_i,
  input  logic [TagWidth-1:0]   tag_i,
  output logic                  valid_o,
  output cast_pkg::unpacked_t   data_o,
  output logic [TagWidth-1:0]   tag_o
);

  // --------------------
  // Float fields
  // --------------------
  logic                          fp_sign;
  logic [cast_pkg::EXP_BITS-1:0] fp_exp;
  logic [cast_pkg::MAN_BITS-1:0] fp_man;
  logic                          exp_zero;
  logic                          exp_ones;
  logic                          man_zero;
  logic                          is_normal;
  cast_pkg::fp_class_t           fp_class;

  assign fp_sign = operand_i[31];
  assign fp_exp  = operand_i[cast_pkg::MAN_BITS +: cast_pkg::EXP_BITS];
  assign fp_man  = operand_i[cast_pkg::MAN_BITS-1:0];

  assign exp_zero  = (fp_exp == '0);
  assign exp_ones  = (fp_exp == '1);
  assign man_zero  = (fp_man == '0);
  assign is_normal = ~exp_zero & ~exp_ones;  // Gets the implicit one

  always_comb begin
    fp_class.is_zero      = exp_zero & man_zero;
    fp_class.is_subnormal = exp_zero & ~man_zero;
    fp_class.is_inf       = exp_ones & man_zero;
    fp_class.is_nan       = exp_ones & ~man_zero;
    // Quiet bit clear on a NaN
    fp_class.is_snan      = exp_ones & ~man_zero & ~fp_man[cast_pkg::MAN_BITS-1];
  end

  // --------------------
  // Integer magnitude
  // --------------------
  logic            int_sign;
  cast_pkg::mant_t int_mag;

  assign int_sign = operand_i[31] & ~is_unsigned_i;  // Unsigned ints are never negative
  assign int_mag  = int_sign ? -operand_i : operand_i;  // 2^31 stays as is

  cast_pkg::unpacked_t data_d;

  always_comb begin
    data_d.op          = op_i;
    data_d.rnd_mode    = rnd_mode_i;
    data_d.is_unsigned = is_unsigned_i;
    if (op_i == cast_pkg::I2F) begin
      data_d.sign       = int_sign;
      data_d.fclass     = '0;  // No class for integers
      data_d.exp_biased = '0;
      data_d.mant       = int_mag;
    end else begin
      data_d.sign       = fp_sign;
      data_d.fclass     = fp_class;
      data_d.exp_biased = fp_exp;
      data_d.mant       = cast_pkg::mant_t'({is_normal, fp_man});  // Zero padded on top
    end
  end

  // --------------------
  // Stage 1 register
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= in_valid_i;
    end
  end

  // Payload only loads on a strobe
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      data_o <= data_d;
      tag_o  <= tag_i;
    end
  end

  a_valid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(valid_o));

endmodule

`default_nettype wire

// File: src/cast_pkg.sv
`default_nettype none

package cast_pkg;

  // --------------------
  // Formats
  // --------------------
  localparam int unsigned INT_WIDTH  = 32;  // Integer side
  localparam int unsigned EXP_BITS   = 8;   // Float32 exponent
  localparam int unsigned MAN_BITS   = 23;  // Float32 fraction
  localparam int unsigned FP_BIAS    = 127;
  // Internal mantissa holds a whole integer or 1.fraction
  localparam int unsigned MANT_WIDTH = (INT_WIDTH > MAN_BITS + 1) ? INT_WIDTH : MAN_BITS + 1;
  localparam int unsigned EXP_WIDTH  = 10;  // Signed, covers -149 .. +128
  localparam int unsigned LZC_WIDTH  = $clog2(MANT_WIDTH) + 1;  // Count 0 .. MANT_WIDTH

  typedef logic signed [EXP_WIDTH-1:0] exp_t;
  typedef logic [MANT_WIDTH-1:0]       mant_t;
  typedef logic [LZC_WIDTH-1:0]        lzc_t;

  // --------------------
  // Operation encodings
  // --------------------
  typedef enum logic {
    F2I = 1'b0,  // Float to integer
    I2F = 1'b1   // Integer to float
  } op_e;

  typedef enum logic {
    RNE = 1'b0,  // Nearest, ties to even
    RTZ = 1'b1   // Truncate
  } rnd_mode_e;

  typedef struct packed {
    logic nv;  // Invalid
    logic nx;  // Inexact
  } status_t;

  // Float operand class
  typedef struct packed {
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_snan;
    logic is_subnormal;
  } fp_class_t;

  // --------------------
  // Stage payloads
  // --------------------
  typedef struct packed {
    op_e                 op;
    rnd_mode_e           rnd_mode;
    logic                is_unsigned;
    logic                sign;
    fp_class_t           fclass;      // Float class, zero for I2F
    logic [EXP_BITS-1:0] exp_biased;  // Raw float exponent
    mant_t               mant;        // Magnitude or 1.fraction
  } unpacked_t;

  typedef struct packed {
    op_e            op;
    rnd_mode_e      rnd_mode;
    logic           is_unsigned;
    logic           sign;
    fp_class_t      fclass;
    logic [31:0]    pre_round;        // {exp, fraction} or integer magnitude
    logic           round_bit;
    logic           sticky_bit;
    logic           of_before_round;  // F2I out of range
    logic           mant_zero;        // Integer zero for I2F
  } aligned_t;

endpackage

`default_nettype wire
